//--- Makefile
# Verilator build and run for the led matrix driver testbench

VERILATOR ?= verilator
TOP       ?= tb_led_matrix
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
logic/led_matrix_pkg.sv
logic/scan_if.sv
logic/uart_rx.sv
logic/command_decoder.sv
logic/frame_buffer.sv
logic/matrix_scan.sv
logic/bitplane_fetch.sv
logic/led_matrix_top.sv
testbench/tb_led_matrix.sv

//--- logic/bitplane_fetch.sv
//////////////////////////////////////////////////////////////////////
// bitplane fetch
// reads the pixel pair for the scan slot and picks the plane bits
//////////////////////////////////////////////////////////////////////
module bitplane_fetch #(
    parameter int  COLUMNS   = led_matrix_pkg::DEF_COLUMNS,
    parameter int  SCAN_ROWS = led_matrix_pkg::DEF_SCAN_ROWS,
    localparam int RD_W      = $clog2(SCAN_ROWS * COLUMNS)
) (
    input  logic                                  clk_root,
    input  logic                                  rst_n,
    scan_if.fetcher                               scan,
    input  led_matrix_pkg::pixel_t                top_pixel,
    input  led_matrix_pkg::pixel_t                bottom_pixel,
    input  logic [2:0]                            channel_enable,
    input  logic [led_matrix_pkg::COLOR_BITS-1:0] plane_enable,
    output logic [RD_W-1:0]                       rd_addr,
    output logic [2:0]                            rgb_top,
    output logic [2:0]                            rgb_bottom
);
    logic pixel_ready;  // buffer output belongs to this slot

    // bit 0 red, bit 1 green, bit 2 blue
    function automatic logic [2:0] plane_bits(led_matrix_pkg::pixel_t px, int plane);
        logic [2:0] bits;
        bits = {px.blue[plane], px.green[plane], px.red[plane]};
        return bits & channel_enable & {3{plane_enable[plane]}};
    endfunction

    assign rd_addr = RD_W'(int'(scan.row) * COLUMNS + int'(scan.column));

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            pixel_ready <= 1'b0;
            rgb_top     <= '0;
            rgb_bottom  <= '0;
        end else begin
            pixel_ready <= scan.load;
            if (pixel_ready) begin
                rgb_top    <= plane_bits(top_pixel, int'(scan.plane));
                rgb_bottom <= plane_bits(bottom_pixel, int'(scan.plane));
            end
        end
    end

endmodule

//--- logic/command_decoder.sv
//////////////////////////////////////////////////////////////////////
// command decoder
// collects opcode operands, writes pixels, runs fills, holds enables
//////////////////////////////////////////////////////////////////////
module command_decoder #(
    parameter int  COLUMNS   = led_matrix_pkg::DEF_COLUMNS,
    parameter int  SCAN_ROWS = led_matrix_pkg::DEF_SCAN_ROWS,
    localparam int PIXELS    = 2 * SCAN_ROWS * COLUMNS,
    localparam int ADDR_W    = $clog2(PIXELS)
) (
    input  logic                                  clk_root,
    input  logic                                  rst_n,
    input  logic [7:0]                            rx_data,
    input  logic                                  rx_valid,
    output logic                                  wr_en,
    output logic [ADDR_W-1:0]                     wr_addr,
    output led_matrix_pkg::pixel_t                wr_pixel,
    output logic [2:0]                            channel_enable,
    output logic [led_matrix_pkg::COLOR_BITS-1:0] plane_enable,
    output logic                                  busy
);
    typedef enum logic [1:0] {S_OPCODE, S_OPERAND, S_FILL} state_t;

    state_t     state;
    logic [7:0] opcode;
    logic [1:0] operand_idx;  // operand bytes taken so far
    logic [7:0] addr_byte;
    logic [7:0] rg_byte;

    // red in the upper nibble, green in the lower, blue from the last byte
    function automatic led_matrix_pkg::pixel_t to_pixel(logic [7:0] rg, logic [7:0] b);
        return '{red: rg[7:4], green: rg[3:0], blue: b[3:0]};
    endfunction

    assign busy = (state == S_FILL);  // incoming bytes are dropped here

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state          <= S_OPCODE;
            wr_en          <= 1'b0;
            channel_enable <= '1;
            plane_enable   <= '1;
        end else begin
            wr_en <= 1'b0;
            case (state)
                S_OPCODE: if (rx_valid) begin
                    opcode      <= rx_data;
                    operand_idx <= '0;
                    // unknown opcodes stay here
                    if (rx_data inside {led_matrix_pkg::CMD_PIXEL, led_matrix_pkg::CMD_FILL,
                                        led_matrix_pkg::CMD_BRIGHTNESS,
                                        led_matrix_pkg::CMD_CHANNEL}) begin
                        state <= S_OPERAND;
                    end
                end
                S_OPERAND: if (rx_valid) begin
                    operand_idx <= operand_idx + 1'b1;
                    case (opcode)
                        led_matrix_pkg::CMD_PIXEL: begin
                            if (operand_idx == 2'd0) addr_byte <= rx_data;
                            if (operand_idx == 2'd1) rg_byte <= rx_data;
                            if (operand_idx == 2'd2) begin
                                wr_en    <= int'(addr_byte) < PIXELS;  // off-panel ignored
                                wr_addr  <= ADDR_W'(addr_byte);
                                wr_pixel <= to_pixel(rg_byte, rx_data);
                                state    <= S_OPCODE;
                            end
                        end
                        led_matrix_pkg::CMD_FILL: begin
                            if (operand_idx == 2'd0) begin
                                rg_byte <= rx_data;
                            end else begin
                                wr_en    <= 1'b1;
                                wr_addr  <= '0;
                                wr_pixel <= to_pixel(rg_byte, rx_data);
                                state    <= S_FILL;
                            end
                        end
                        led_matrix_pkg::CMD_BRIGHTNESS: begin
                            plane_enable <= rx_data[led_matrix_pkg::COLOR_BITS-1:0];
                            state        <= S_OPCODE;
                        end
                        default: begin
                            channel_enable <= rx_data[2:0];  // bit 0 red .. bit 2 blue
                            state          <= S_OPCODE;
                        end
                    endcase
                end
                default: begin
                    // one pixel per cycle until the last address
                    if (int'(wr_addr) == PIXELS - 1) begin
                        state <= S_OPCODE;
                    end else begin
                        wr_en   <= 1'b1;
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
            endcase
        end
    end

    a_addr_range: assert property (@(posedge clk_root) disable iff (!rst_n)
        wr_en |-> int'(wr_addr) < PIXELS)
        else $error("write outside the panel");

endmodule

//--- logic/frame_buffer.sv
//////////////////////////////////////////////////////////////////////
// frame buffer
// top and bottom half banks, one write port, paired registered read
//////////////////////////////////////////////////////////////////////
module frame_buffer #(
    parameter int  COLUMNS   = led_matrix_pkg::DEF_COLUMNS,
    parameter int  SCAN_ROWS = led_matrix_pkg::DEF_SCAN_ROWS,
    localparam int HALF      = SCAN_ROWS * COLUMNS,
    localparam int ADDR_W    = $clog2(2 * HALF),
    localparam int RD_W      = $clog2(HALF)
) (
    input  logic                   clk_root,
    input  logic                   wr_en,
    input  logic [ADDR_W-1:0]      wr_addr,
    input  led_matrix_pkg::pixel_t wr_pixel,
    input  logic [RD_W-1:0]        rd_addr,
    output led_matrix_pkg::pixel_t top_pixel,
    output led_matrix_pkg::pixel_t bottom_pixel
);
    led_matrix_pkg::pixel_t top_mem    [HALF];
    led_matrix_pkg::pixel_t bottom_mem [HALF];

    logic            in_bottom;  // row at or above SCAN_ROWS
    logic [RD_W-1:0] bank_addr;

    assign in_bottom = int'(wr_addr) >= HALF;
    assign bank_addr = RD_W'(in_bottom ? int'(wr_addr) - HALF : int'(wr_addr));

    always_ff @(posedge clk_root) begin
        if (wr_en && !in_bottom) top_mem[bank_addr] <= wr_pixel;
        if (wr_en && in_bottom) bottom_mem[bank_addr] <= wr_pixel;
        top_pixel    <= top_mem[rd_addr];
        bottom_pixel <= bottom_mem[rd_addr];
    end

endmodule

//--- logic/led_matrix_pkg.sv
//////////////////////////////////////////////////////////////////////
// led matrix shared definitions
// pixel format, command opcodes and default sizes
//////////////////////////////////////////////////////////////////////
package led_matrix_pkg;

    // brightness bits per channel
    localparam int COLOR_BITS = 4;

    typedef struct packed {
        logic [COLOR_BITS-1:0] red;
        logic [COLOR_BITS-1:0] green;
        logic [COLOR_BITS-1:0] blue;
    } pixel_t;

    // command opcodes, ascii letters
    localparam logic [7:0] CMD_PIXEL      = 8'h50;  // 'P' addr, rg, b
    localparam logic [7:0] CMD_FILL       = 8'h46;  // 'F' rg, b
    localparam logic [7:0] CMD_BRIGHTNESS = 8'h42;  // 'B' plane mask
    localparam logic [7:0] CMD_CHANNEL    = 8'h45;  // 'E' rgb mask

    // default geometry and timing
    localparam int DEF_COLUMNS        = 16;
    localparam int DEF_SCAN_ROWS      = 4;  // panel has twice this many rows
    localparam int DEF_TICKS_PER_BIT  = 8;
    localparam int DEF_BASE_ON_CYCLES = 4;

endpackage

//--- logic/led_matrix_top.sv
//////////////////////////////////////////////////////////////////////
// led matrix driver top level
// serial commands into the frame buffer, hub75 scan out
//////////////////////////////////////////////////////////////////////
module led_matrix_top #(
    parameter int  COLUMNS        = led_matrix_pkg::DEF_COLUMNS,
    parameter int  SCAN_ROWS      = led_matrix_pkg::DEF_SCAN_ROWS,
    parameter int  TICKS_PER_BIT  = led_matrix_pkg::DEF_TICKS_PER_BIT,
    parameter int  BASE_ON_CYCLES = led_matrix_pkg::DEF_BASE_ON_CYCLES,
    localparam int ROW_W          = $clog2(SCAN_ROWS)
) (
    input  logic             clk_root,
    input  logic             rst_n,
    input  logic             uart_rxd,
    output logic [2:0]       rgb_top,
    output logic [2:0]       rgb_bottom,
    output logic [ROW_W-1:0] row_select,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             output_enable,
    output logic             busy
);
    localparam int ADDR_W = $clog2(2 * SCAN_ROWS * COLUMNS);
    localparam int RD_W   = $clog2(SCAN_ROWS * COLUMNS);

    logic [7:0]                            rx_data;
    logic                                  rx_valid;
    logic                                  wr_en;
    logic [ADDR_W-1:0]                     wr_addr;
    led_matrix_pkg::pixel_t                wr_pixel;
    logic [2:0]                            channel_enable;
    logic [led_matrix_pkg::COLOR_BITS-1:0] plane_enable;
    logic [RD_W-1:0]                       rd_addr;
    led_matrix_pkg::pixel_t                top_pixel;
    led_matrix_pkg::pixel_t                bottom_pixel;

    scan_if #(.COLUMNS(COLUMNS), .SCAN_ROWS(SCAN_ROWS)) scan ();

    uart_rx #(.TICKS_PER_BIT(TICKS_PER_BIT)) u_uart_rx (
        .clk_root, .rst_n, .rxd(uart_rxd), .rx_data, .rx_valid
    );

    command_decoder #(.COLUMNS(COLUMNS), .SCAN_ROWS(SCAN_ROWS)) u_command_decoder (
        .clk_root, .rst_n, .rx_data, .rx_valid, .wr_en, .wr_addr, .wr_pixel,
        .channel_enable, .plane_enable, .busy
    );

    frame_buffer #(.COLUMNS(COLUMNS), .SCAN_ROWS(SCAN_ROWS)) u_frame_buffer (
        .clk_root, .wr_en, .wr_addr, .wr_pixel, .rd_addr, .top_pixel, .bottom_pixel
    );

    matrix_scan #(
        .COLUMNS(COLUMNS), .SCAN_ROWS(SCAN_ROWS), .BASE_ON_CYCLES(BASE_ON_CYCLES)
    ) u_matrix_scan (
        .clk_root, .rst_n, .scan(scan.scanner), .clk_pixel, .row_latch,
        .output_enable, .row_select
    );

    bitplane_fetch #(.COLUMNS(COLUMNS), .SCAN_ROWS(SCAN_ROWS)) u_bitplane_fetch (
        .clk_root, .rst_n, .scan(scan.fetcher), .top_pixel, .bottom_pixel,
        .channel_enable, .plane_enable, .rd_addr, .rgb_top, .rgb_bottom
    );

endmodule

//--- logic/matrix_scan.sv
//////////////////////////////////////////////////////////////////////
// matrix scanner
// shifts columns per bitplane, latches the row, then lights it for a
// binary weighted time before moving to the next plane and row
//////////////////////////////////////////////////////////////////////
module matrix_scan #(
    parameter int  COLUMNS        = led_matrix_pkg::DEF_COLUMNS,
    parameter int  SCAN_ROWS      = led_matrix_pkg::DEF_SCAN_ROWS,
    parameter int  BASE_ON_CYCLES = led_matrix_pkg::DEF_BASE_ON_CYCLES,
    localparam int ROW_W          = $clog2(SCAN_ROWS),
    localparam int MAX_ON         = BASE_ON_CYCLES << (led_matrix_pkg::COLOR_BITS - 1),
    localparam int ON_W           = $clog2(MAX_ON + 1)
) (
    input  logic             clk_root,
    input  logic             rst_n,
    scan_if.scanner          scan,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             output_enable,
    output logic [ROW_W-1:0] row_select
);
    typedef enum logic [1:0] {S_SHIFT, S_LATCH, S_DISPLAY} state_t;

    state_t          state;
    logic [1:0]      phase;   // cycle within a column slot
    logic [ON_W-1:0] on_cnt;
    logic            last_column;
    logic            last_plane;
    logic            last_row;
    logic            on_done;

    assign scan.load   = (state == S_SHIFT) && (phase == 2'd0);
    assign last_column = int'(scan.column) == COLUMNS - 1;
    assign last_plane  = int'(scan.plane) == led_matrix_pkg::COLOR_BITS - 1;
    assign last_row    = int'(scan.row) == SCAN_ROWS - 1;
    assign on_done     = int'(on_cnt) == (BASE_ON_CYCLES << scan.plane) - 1;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state         <= S_SHIFT;
            phase         <= '0;
            on_cnt        <= '0;
            scan.column   <= '0;
            scan.row      <= '0;
            scan.plane    <= '0;
            clk_pixel     <= 1'b0;
            row_latch     <= 1'b0;
            output_enable <= 1'b0;
            row_select    <= '0;
        end else begin
            row_latch <= 1'b0;
            case (state)
                S_SHIFT: begin
                    phase     <= phase + 1'b1;
                    clk_pixel <= (phase == 2'd1) || (phase == 2'd2);  // high in cycles 2, 3
                    if (phase == 2'd3) begin
                        if (last_column) begin
                            state      <= S_LATCH;
                            row_latch  <= 1'b1;
                            row_select <= scan.row;
                        end else begin
                            scan.column <= scan.column + 1'b1;
                        end
                    end
                end
                S_LATCH: begin
                    state         <= S_DISPLAY;
                    output_enable <= 1'b1;
                    on_cnt        <= '0;
                end
                default: begin
                    on_cnt <= on_cnt + 1'b1;
                    if (on_done) begin
                        output_enable <= 1'b0;
                        state         <= S_SHIFT;
                        scan.column   <= '0;
                        if (last_plane) begin
                            scan.plane <= '0;
                            scan.row   <= last_row ? '0 : scan.row + 1'b1;
                        end else begin
                            scan.plane <= scan.plane + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    a_latch_blanked: assert property (@(posedge clk_root) disable iff (!rst_n)
        row_latch |-> !output_enable)
        else $error("row latched while the panel is lit");

endmodule

//--- logic/scan_if.sv
//////////////////////////////////////////////////////////////////////
// scan position from the matrix scanner to the bitplane fetch
//////////////////////////////////////////////////////////////////////
interface scan_if #(
    parameter int COLUMNS   = led_matrix_pkg::DEF_COLUMNS,
    parameter int SCAN_ROWS = led_matrix_pkg::DEF_SCAN_ROWS
);
    logic [$clog2(COLUMNS)-1:0]                    column;
    logic [$clog2(SCAN_ROWS)-1:0]                  row;    // row pair being shifted
    logic [$clog2(led_matrix_pkg::COLOR_BITS)-1:0] plane;
    logic                                          load;   // first cycle of a column slot

    modport scanner (output column, row, plane, load);
    modport fetcher (input column, row, plane, load);

endinterface

//--- logic/uart_rx.sv
//////////////////////////////////////////////////////////////////////
// uart receiver
// two-flop input synchronizer, 8N1 framing, mid-bit sampling
//////////////////////////////////////////////////////////////////////
module uart_rx #(
    parameter int TICKS_PER_BIT = led_matrix_pkg::DEF_TICKS_PER_BIT
) (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int CNT_W = $clog2(TICKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(TICKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(TICKS_PER_BIT - 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t           state;
    logic [1:0]       rxd_sync;
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_cnt;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            rxd_sync <= 2'b11;  // line idles high
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    tick_cnt <= '0;
                    if (!rxd_sync[1]) state <= S_START;
                end
                S_START: if (tick_cnt == HALF_BIT) begin
                    // still low at half a bit, so a real start bit
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    state    <= rxd_sync[1] ? S_IDLE : S_DATA;
                end
                S_DATA: if (tick_cnt == FULL_BIT) begin
                    tick_cnt <= '0;
                    rx_data  <= {rxd_sync[1], rx_data[7:1]};  // lsb first
                    bit_cnt  <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= S_STOP;
                end
                default: if (tick_cnt == FULL_BIT) begin
                    rx_valid <= rxd_sync[1];  // framing error drops the byte
                    state    <= S_IDLE;
                end
            endcase
        end
    end

    a_valid_single: assert property (@(posedge clk_root) disable iff (!rst_n)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held for two cycles");

endmodule

//--- testbench/tb_led_matrix.sv
//////////////////////////////////////////////////////////////////////
// led matrix driver testbench
// uart commands in, panel scan sampled and compared with a model
//////////////////////////////////////////////////////////////////////
module tb_led_matrix;

    localparam int COLUMNS        = led_matrix_pkg::DEF_COLUMNS;
    localparam int SCAN_ROWS      = led_matrix_pkg::DEF_SCAN_ROWS;
    localparam int TICKS_PER_BIT  = led_matrix_pkg::DEF_TICKS_PER_BIT;
    localparam int BASE_ON_CYCLES = led_matrix_pkg::DEF_BASE_ON_CYCLES;
    localparam int COLOR_BITS     = led_matrix_pkg::COLOR_BITS;
    localparam int HALF           = SCAN_ROWS * COLUMNS;
    localparam int PIXELS         = 2 * HALF;
    localparam int ROW_W          = $clog2(SCAN_ROWS);
    localparam int PIXEL_W        = $bits(led_matrix_pkg::pixel_t);
    localparam int FRAME_LATCHES  = SCAN_ROWS * COLOR_BITS;
    localparam int BUSY_TIMEOUT   = 4 * PIXELS + 20 * TICKS_PER_BIT;
    localparam int LATCH_TIMEOUT  = 4 * COLUMNS + (BASE_ON_CYCLES << COLOR_BITS) + 16;

    logic             clk_root = 1'b0;
    logic             rst_n;
    logic             uart_rxd;
    logic [2:0]       rgb_top;
    logic [2:0]       rgb_bottom;
    logic [ROW_W-1:0] row_select;
    logic             clk_pixel;
    logic             row_latch;
    logic             output_enable;
    logic             busy;

    // reference model of the frame buffer and both enables
    led_matrix_pkg::pixel_t  model_fb [PIXELS];
    logic [2:0]              model_chan;
    logic [COLOR_BITS-1:0]   model_planes;

    logic [31:0]      lfsr_state;
    logic             check_en;     // compare rows only inside a check window
    logic             aborted;      // set by a timed out wait
    int               errors;
    int               checks;
    int               oe_periods;
    int               oe_seen [COLOR_BITS];

    // sampler state
    logic [2:0]       top_samples [COLUMNS];
    logic [2:0]       bot_samples [COLUMNS];
    int               sample_cnt;
    logic             clk_pixel_q;
    logic [ROW_W-1:0] last_row;
    int               plane_idx;
    int               oe_cycles;

    always #2 clk_root = ~clk_root;

    led_matrix_top dut (
        .clk_root, .rst_n, .uart_rxd, .rgb_top, .rgb_bottom, .row_select,
        .clk_pixel, .row_latch, .output_enable, .busy
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic led_matrix_pkg::pixel_t random_pixel();
        logic [PIXEL_W-1:0] raw;
        raw = PIXEL_W'(random_bits(PIXEL_W));
        return raw;
    endfunction

    // channel bits of one panel position, bit 0 red .. bit 2 blue
    function automatic logic [2:0] expected_bits(int row, int col, int plane, int half);
        led_matrix_pkg::pixel_t px;
        logic [2:0]             bits;
        px   = model_fb[(half * SCAN_ROWS + row) * COLUMNS + col];
        bits = {px.blue[plane], px.green[plane], px.red[plane]};
        if (!model_planes[plane]) bits = 3'b000;  // plane switched off
        return bits & model_chan;
    endfunction

    task automatic compare_row(input int row, input int plane);
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        if (sample_cnt != COLUMNS) begin
            $display("row %0d plane %0d shifted %0d columns instead of %0d",
                     row, plane, sample_cnt, COLUMNS);
            errors++;
        end
        for (int c = 0; c < COLUMNS; c++) begin
            exp_top = expected_bits(row, c, plane, 0);
            exp_bot = expected_bits(row, c, plane, 1);
            checks += 2;
            if (top_samples[c] !== exp_top) begin
                $display("[ERROR] rgb_top row %0d col %0d plane %0d: expected %h, got %h",
                         row, c, plane, exp_top, top_samples[c]);
                errors++;
            end
            if (bot_samples[c] !== exp_bot) begin
                $display("[ERROR] rgb_bottom row %0d col %0d plane %0d: expected %h, got %h",
                         row, c, plane, exp_bot, bot_samples[c]);
                errors++;
            end
        end
    endtask

    // panel sampler, checks each latched row and every display period
    always @(posedge clk_root) begin
        if (!rst_n) begin
            sample_cnt  = 0;
            clk_pixel_q = 1'b0;
            last_row    = '0;
            plane_idx   = COLOR_BITS - 1;  // first latch is plane 0
            oe_cycles   = 0;
        end else begin
            if (clk_pixel && !clk_pixel_q) begin
                if (sample_cnt < COLUMNS) begin
                    top_samples[sample_cnt] = rgb_top;
                    bot_samples[sample_cnt] = rgb_bottom;
                end
                sample_cnt++;
            end
            clk_pixel_q = clk_pixel;
            if (row_latch) begin
                plane_idx = (row_select == last_row) ? (plane_idx + 1) % COLOR_BITS : 0;
                last_row  = row_select;
                if (check_en) compare_row(int'(row_select), plane_idx);
                sample_cnt = 0;
            end
            if (output_enable) begin
                oe_cycles++;
            end else if (oe_cycles != 0) begin
                oe_periods++;
                oe_seen[plane_idx]++;
                if (oe_cycles != (BASE_ON_CYCLES << plane_idx)) begin
                    $display("[ERROR] output_enable high cycles plane %0d: expected %h, got %h",
                             plane_idx, BASE_ON_CYCLES << plane_idx, oe_cycles);
                    errors++;
                end
                oe_cycles = 0;
            end
        end
    end

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rxd <= frame[i];
            repeat (TICKS_PER_BIT) @(posedge clk_root);
        end
    endtask

    task automatic send_command(input logic [7:0] opcode, input logic [7:0] value);
        send_byte(opcode);
        send_byte(value);
    endtask

    task automatic send_pixel(input int addr, input led_matrix_pkg::pixel_t px);
        send_byte(led_matrix_pkg::CMD_PIXEL);
        send_byte(8'(addr));
        send_byte({px.red, px.green});
        send_byte(8'(px.blue));
        model_fb[addr] = px;
    endtask

    task automatic send_fill(input led_matrix_pkg::pixel_t px);
        send_byte(led_matrix_pkg::CMD_FILL);
        send_byte({px.red, px.green});
        send_byte(8'(px.blue));
        for (int a = 0; a < PIXELS; a++) begin
            model_fb[a] = px;
        end
    endtask

    task automatic wait_busy(input logic level);
        int cycles;
        cycles = 0;
        if (aborted) return;
        while (busy !== level && cycles < BUSY_TIMEOUT) begin
            @(posedge clk_root);
            cycles++;
        end
        if (busy !== level) begin
            $display("timeout waiting for busy to go %s", level ? "high" : "low");
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_latch();
        int cycles;
        cycles = 0;
        if (aborted) return;
        do begin
            @(posedge clk_root);
            cycles++;
        end while (!row_latch && cycles < LATCH_TIMEOUT);
        if (!row_latch) begin
            $display("timeout waiting for a row latch");
            errors++;
            aborted = 1'b1;
        end
    endtask

    // skip the row in flight, then compare one whole frame
    task automatic check_frame();
        wait_latch();
        check_en <= 1'b1;
        repeat (FRAME_LATCHES) wait_latch();
        check_en <= 1'b0;
    endtask

    initial begin
        led_matrix_pkg::pixel_t colour;
        rst_n        = 1'b0;
        uart_rxd     = 1'b1;
        check_en     = 1'b0;
        aborted      = 1'b0;
        errors       = 0;
        checks       = 0;
        oe_periods   = 0;
        lfsr_state   = 32'h6cae;
        model_chan   = 3'b111;
        model_planes = '1;
        for (int p = 0; p < COLOR_BITS; p++) begin
            oe_seen[p] = 0;
        end
        repeat (2) @(posedge clk_root);
        rst_n <= 1'b1;

        // idle outputs before the first latch
        for (int i = 0; i < 2 * COLUMNS; i++) begin
            @(posedge clk_root);
            checks++;
            if ({output_enable, row_latch, busy, row_select} !== '0) begin
                $display("[ERROR] output_enable/row_latch/busy/row_select: expected 0, got %h",
                         {output_enable, row_latch, busy, row_select});
                errors++;
            end
        end

        colour = random_pixel();
        send_fill(colour);
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_frame();

        // alternate top and bottom half rows
        for (int i = 0; i < 8; i++) begin
            send_pixel((i % 2) * HALF + random_bits($clog2(HALF)), random_pixel());
        end
        check_frame();

        send_command(led_matrix_pkg::CMD_CHANNEL, 8'h05);  // green off
        model_chan = 3'b101;
        check_frame();

        send_command(led_matrix_pkg::CMD_CHANNEL, 8'h07);
        send_command(led_matrix_pkg::CMD_BRIGHTNESS, 8'h05);  // planes 1 and 3 off
        model_chan   = 3'b111;
        model_planes = 4'b0101;
        check_frame();

        send_command(led_matrix_pkg::CMD_BRIGHTNESS, 8'h0f);
        model_planes = '1;
        colour = random_pixel();
        send_fill(colour);
        send_byte(led_matrix_pkg::CMD_PIXEL);  // lands during the fill and is dropped
        if (busy !== 1'b1) begin
            $display("fill ended before the extra byte was received");
            errors++;
        end
        wait_busy(1'b0);
        send_byte(8'h5a);  // unknown opcode
        check_frame();
        send_pixel(random_bits($clog2(PIXELS)), random_pixel());
        check_frame();

        for (int p = 0; p < COLOR_BITS; p++) begin
            if (oe_seen[p] == 0) begin
                $display("no display period seen for plane %0d", p);
                errors++;
            end
        end

        $display("checks %0d, errors %0d, display periods %0d", checks, errors, oe_periods);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
